// File: Makefile
# Verilator flow for the miss unit

VERILATOR ?= verilator
TOP       ?= miss_unit_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing
FAIL_MSG  ?= Some tests failed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi; \
	exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: logic/miss_ctrl_fsm.sv
//**************************************
// Miss control FSM
// Check, allocate and refill issue for each core miss
//**************************************
module miss_ctrl_fsm (
    input  logic clk_i,
    input  logic rst_ni,

    // Core miss request
    input  logic miss_req_valid_i,

    // Memory response present this cycle
    input  logic busy_i,

    // Check results and credit state
    input  logic hit_i,
    input  logic alloc_full_i,
    input  logic credit_avail_i,

    // Commands
    output logic check_o,
    output logic alloc_o,
    output logic miss_req_ready_o
);

    typedef enum logic {
        IDLE,
        CHECK
    } state_e;

    state_e state_q;
    state_e state_d;
    logic   start;
    logic   accept;

    // A response needs the store this cycle, so hold off
    assign start = miss_req_valid_i & ~busy_i;

    // All four conditions for taking the miss
    assign accept = miss_req_valid_i
                  & ~hit_i
                  & ~alloc_full_i
                  & credit_avail_i
                  & ~busy_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (start) begin
                    state_d = CHECK;
                end
            end
            // Accepted or abandoned, always back to IDLE
            CHECK: begin
                state_d = IDLE;
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    always_comb begin
        check_o          = 1'b0;
        alloc_o          = 1'b0;
        miss_req_ready_o = 1'b0;
        case (state_q)
            IDLE: begin
                check_o = start;
            end
            CHECK: begin
                // Allocation and refill issue in the same cycle
                alloc_o          = accept;
                miss_req_ready_o = accept;
            end
            default: begin
                check_o = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

// File: logic/miss_pkg.sv
//**************************************
// Miss unit package
// Sizing constants and the request, entry and response types
//**************************************
package miss_pkg;

    // MSHR geometry
    localparam int MSHR_SETS  = 4;
    localparam int MSHR_WAYS  = 2;
    localparam int MSHR_SET_W = 2;
    localparam int MSHR_WAY_W = 1;

    // Cache address split, the line number is the tag above the set
    localparam int CACHE_SET_W = 6;
    localparam int TAG_W       = 20;
    localparam int NLINE_W     = TAG_W + CACHE_SET_W;

    // Request fields
    localparam int TID_W  = 4;
    localparam int SID_W  = 2;
    localparam int WORD_W = 3;
    localparam int DATA_W = 32;

    // Memory request credits
    localparam int REFILL_CREDITS = 2;
    localparam int CREDIT_W       = $clog2(REFILL_CREDITS + 1);

    typedef struct packed {
        logic [NLINE_W-1:0] nline;
        logic [TID_W-1:0]   tid;
        logic [SID_W-1:0]   sid;
        logic [WORD_W-1:0]  word;
        logic               need_rsp;
        logic               is_prefetch;
    } miss_req_t;

    // Fields kept per MSHR entry, cache set lives in flops beside it
    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [TID_W-1:0]  tid;
        logic [SID_W-1:0]  sid;
        logic [WORD_W-1:0] word;
        logic              need_rsp;
        logic              is_prefetch;
    } mshr_entry_t;

    typedef struct packed {
        logic [MSHR_WAY_W-1:0] way;
        logic [MSHR_SET_W-1:0] set;
    } refill_loc_t;

    // Memory sees a flat slot, the MSHR sees way and set
    typedef union packed {
        logic [MSHR_WAY_W+MSHR_SET_W-1:0] slot;
        refill_loc_t                      loc;
    } refill_id_u;

    typedef struct packed {
        logic [NLINE_W-1:0] nline;
        refill_id_u         id;
    } mem_req_t;

    typedef struct packed {
        refill_id_u         id;
        logic [DATA_W-1:0]  data;
    } mem_rsp_t;

    typedef struct packed {
        logic [TID_W-1:0]  tid;
        logic [SID_W-1:0]  sid;
        logic [WORD_W-1:0] word;
        logic [DATA_W-1:0] data;
    } core_rsp_t;

endpackage

// File: logic/miss_unit.sv
//**************************************
// Miss unit
// MSHR store, control FSM, credits and response stage
//**************************************
module miss_unit (
    input  logic                  clk_i,
    input  logic                  rst_ni,

    // Core miss requests
    input  logic                  miss_req_valid_i,
    input  miss_pkg::miss_req_t   miss_req_i,
    output logic                  miss_req_ready_o,

    // Refill requests, credit based
    output logic                  mem_req_valid_o,
    output miss_pkg::mem_req_t    mem_req_o,
    input  logic                  mem_credit_i,

    // Refill answers
    input  logic                  mem_rsp_valid_i,
    input  miss_pkg::mem_rsp_t    mem_rsp_i,

    // Core responses
    output logic                  core_rsp_valid_o,
    output miss_pkg::core_rsp_t   core_rsp_o,

    output logic                  mshr_empty_o,
    output logic                  mshr_full_o
);
    import miss_pkg::*;

    logic        check;
    logic        alloc;
    logic        hit;
    logic        alloc_full;
    logic        credit_avail;
    refill_id_u  alloc_id;
    mshr_entry_t ack_entry;

    mshr_store u_mshr_store (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .check_i       (check),
        .check_nline_i (miss_req_i.nline),
        .hit_o         (hit),
        .alloc_full_o  (alloc_full),
        .alloc_i       (alloc),
        .alloc_req_i   (miss_req_i),
        .alloc_id_o    (alloc_id),
        .ack_i         (mem_rsp_valid_i),
        .ack_id_i      (mem_rsp_i.id),
        .ack_entry_o   (ack_entry),
        .empty_o       (mshr_empty_o),
        .full_o        (mshr_full_o)
    );

    // A memory answer owns the store in its cycle
    miss_ctrl_fsm u_miss_ctrl_fsm (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .miss_req_valid_i (miss_req_valid_i),
        .busy_i           (mem_rsp_valid_i),
        .hit_i            (hit),
        .alloc_full_i     (alloc_full),
        .credit_avail_i   (credit_avail),
        .check_o          (check),
        .alloc_o          (alloc),
        .miss_req_ready_o (miss_req_ready_o)
    );

    refill_credits u_refill_credits (
        .clk_i    (clk_i),
        .rst_ni   (rst_ni),
        .take_i   (alloc),
        .return_i (mem_credit_i),
        .avail_o  (credit_avail)
    );

    refill_rsp_stage u_refill_rsp_stage (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .rsp_valid_i      (mem_rsp_valid_i),
        .rsp_data_i       (mem_rsp_i.data),
        .entry_i          (ack_entry),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_o       (core_rsp_o)
    );

    // Refill goes out in the allocation cycle
    assign mem_req_valid_o = alloc;

    always_comb begin
        mem_req_o.nline = miss_req_i.nline;
        mem_req_o.id    = alloc_id;
    end

endmodule

// File: logic/mshr_store.sv
//**************************************
// MSHR store
// Pending refill entries with check, allocate and acknowledge
//**************************************
module mshr_store (
    input  logic                         clk_i,
    input  logic                         rst_ni,

    // Check, result one cycle later
    input  logic                         check_i,
    input  logic [miss_pkg::NLINE_W-1:0] check_nline_i,
    output logic                         hit_o,
    output logic                         alloc_full_o,

    // Allocate
    input  logic                         alloc_i,
    input  miss_pkg::miss_req_t          alloc_req_i,
    output miss_pkg::refill_id_u         alloc_id_o,

    // Acknowledge, entry one cycle later
    input  logic                         ack_i,
    input  miss_pkg::refill_id_u         ack_id_i,
    output miss_pkg::mshr_entry_t        ack_entry_o,

    output logic                         empty_o,
    output logic                         full_o
);
    import miss_pkg::*;

    logic [MSHR_SETS*MSHR_WAYS-1:0] valid_q;
    logic [MSHR_SETS*MSHR_WAYS-1:0] valid_d;
    logic [CACHE_SET_W-1:0]         cache_set_q [MSHR_SETS*MSHR_WAYS];
    logic [CACHE_SET_W-1:0]         check_cache_set_q;

    // Entry bank, one row per MSHR set, read with one cycle latency
    mshr_entry_t                    bank_q [MSHR_SETS][MSHR_WAYS];
    mshr_entry_t [MSHR_WAYS-1:0]    rdata_q;
    mshr_entry_t                    alloc_entry;

    logic [MSHR_SET_W-1:0]          check_set;
    logic [MSHR_SET_W-1:0]          alloc_set;
    logic [MSHR_SET_W-1:0]          bank_addr;
    logic [MSHR_WAY_W-1:0]          alloc_way;
    logic [MSHR_WAY_W-1:0]          ack_way_q;
    logic                           bank_cs;

    assign check_set = check_cache_set_q[MSHR_SET_W-1:0];
    assign alloc_set = alloc_req_i.nline[MSHR_SET_W-1:0];

    // Acknowledge first, then allocation, then check
    assign bank_cs   = check_i | alloc_i | ack_i;
    assign bank_addr = ack_i   ? ack_id_i.loc.set :
                       alloc_i ? alloc_set : check_nline_i[MSHR_SET_W-1:0];

    // Lowest free way of the allocation set
    always_comb begin : alloc_way_comb
        logic found;
        found     = 1'b0;
        alloc_way = '0;
        for (int w = 0; w < MSHR_WAYS; w++) begin
            if (!found && !valid_q[w*MSHR_SETS + int'(alloc_set)]) begin
                alloc_way = MSHR_WAY_W'(w);
                found     = 1'b1;
            end
        end
        alloc_id_o.loc.way = alloc_way;
        alloc_id_o.loc.set = alloc_set;
    end

    always_comb begin
        alloc_entry.tag         = alloc_req_i.nline[NLINE_W-1:CACHE_SET_W];
        alloc_entry.tid         = alloc_req_i.tid;
        alloc_entry.sid         = alloc_req_i.sid;
        alloc_entry.word        = alloc_req_i.word;
        alloc_entry.need_rsp    = alloc_req_i.need_rsp;
        alloc_entry.is_prefetch = alloc_req_i.is_prefetch;
    end

    // Second cycle of a check, compare every way of the set
    always_comb begin : hit_comb
        logic [MSHR_WAYS-1:0] way_hit;
        logic [MSHR_WAYS-1:0] way_used;
        for (int w = 0; w < MSHR_WAYS; w++) begin
            way_used[w] = valid_q[w*MSHR_SETS + int'(check_set)];
            way_hit[w]  = way_used[w]
                && (cache_set_q[w*MSHR_SETS + int'(check_set)] == check_cache_set_q)
                && (rdata_q[w].tag == check_nline_i[NLINE_W-1:CACHE_SET_W]);
        end
        hit_o        = |way_hit;
        alloc_full_o = &way_used;
    end

    // Slot index is the flat view of the refill id
    always_comb begin
        valid_d = valid_q;
        if (alloc_i) begin
            valid_d[alloc_id_o.slot] = 1'b1;
        end
        if (ack_i) begin
            valid_d[ack_id_i.slot] = 1'b0;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q           <= '0;
            check_cache_set_q <= '0;
        end else begin
            valid_q <= valid_d;
            if (check_i) begin
                check_cache_set_q <= check_nline_i[CACHE_SET_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (alloc_i) begin
            bank_q[alloc_set][alloc_way]  <= alloc_entry;
            cache_set_q[alloc_id_o.slot] <= alloc_req_i.nline[CACHE_SET_W-1:0];
        end
        if (bank_cs) begin
            for (int w = 0; w < MSHR_WAYS; w++) begin
                rdata_q[w] <= bank_q[bank_addr][w];
            end
        end
        if (ack_i) begin
            ack_way_q <= ack_id_i.loc.way;
        end
    end

    assign ack_entry_o = rdata_q[ack_way_q];
    assign empty_o     = ~|valid_q;
    assign full_o      = &valid_q;

endmodule

// File: logic/refill_credits.sv
//**************************************
// Refill credits
// Up/down counter of memory request credits
//**************************************
module refill_credits (
    input  logic clk_i,
    input  logic rst_ni,
    input  logic take_i,
    input  logic return_i,
    output logic avail_o
);
    import miss_pkg::*;

    logic [CREDIT_W-1:0] count_q;
    logic                can_dec;
    logic                can_inc;

    // Saturate at both ends
    assign can_dec = (count_q != '0);
    assign can_inc = (count_q != CREDIT_W'(REFILL_CREDITS));

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            count_q <= CREDIT_W'(REFILL_CREDITS);
        end else begin
            // Take and return together cancel out
            if (take_i && !return_i && can_dec) begin
                count_q <= count_q - CREDIT_W'(1);
            end else if (return_i && !take_i && can_inc) begin
                count_q <= count_q + CREDIT_W'(1);
            end
        end
    end

    assign avail_o = can_dec;

endmodule

// File: logic/refill_rsp_stage.sv
//**************************************
// Refill response stage
// Joins a memory answer with its MSHR entry
//**************************************
module refill_rsp_stage (
    input  logic                        clk_i,
    input  logic                        rst_ni,

    // Memory answer
    input  logic                        rsp_valid_i,
    input  logic [miss_pkg::DATA_W-1:0] rsp_data_i,

    // Entry read from the store, one cycle after the ack
    input  miss_pkg::mshr_entry_t       entry_i,

    output logic                        core_rsp_valid_o,
    output miss_pkg::core_rsp_t         core_rsp_o
);
    import miss_pkg::*;

    logic              rsp_valid_q;
    logic [DATA_W-1:0] rsp_data_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= 1'b0;
        end else begin
            rsp_valid_q <= rsp_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rsp_valid_i) begin
            rsp_data_q <= rsp_data_i;
        end
    end

    // Prefetches and other silent misses give no core response
    assign core_rsp_valid_o = rsp_valid_q & entry_i.need_rsp;

    always_comb begin
        core_rsp_o.tid  = entry_i.tid;
        core_rsp_o.sid  = entry_i.sid;
        core_rsp_o.word = entry_i.word;
        core_rsp_o.data = rsp_data_q;
    end

endmodule

// File: project.f
logic/miss_pkg.sv
logic/mshr_store.sv
logic/miss_ctrl_fsm.sv
logic/refill_credits.sv
logic/refill_rsp_stage.sv
logic/miss_unit.sv
verification/miss_unit_tb.sv

// File: verification/miss_unit_tb.sv
//**************************************
// Miss unit testbench
// Table of misses against a memory model with random latency
//**************************************
module miss_unit_tb;
    import miss_pkg::*;

    localparam int NUM_ROWS    = 14;
    localparam int NUM_SLOTS   = MSHR_SETS * MSHR_WAYS;
    localparam int ID_W        = MSHR_WAY_W + MSHR_SET_W;
    localparam int TIMEOUT_CYC = NUM_ROWS * 40 + 200;

    typedef struct {
        logic [NLINE_W-1:0] nline;
        logic [TID_W-1:0]   tid;
        logic [SID_W-1:0]   sid;
        logic [WORD_W-1:0]  word;
        logic               need_rsp;
        logic               is_prefetch;
        logic               exp_rsp;
        int                 pause;
    } row_t;

    // nline, tid, sid, word, need_rsp, is_prefetch, core rsp expected, credit pause cycles
    row_t stim_table [NUM_ROWS] = '{
        '{26'h0000041, 4'd1,  2'd0, 3'd3, 1'b1, 1'b0, 1'b1, 0},
        '{26'h0000082, 4'd2,  2'd1, 3'd5, 1'b1, 1'b0, 1'b1, 0},
        '{26'h0000041, 4'd3,  2'd2, 3'd0, 1'b1, 1'b0, 1'b1, 0},
        '{26'h0000105, 4'd4,  2'd0, 3'd1, 1'b1, 1'b0, 1'b1, 0},
        '{26'h0000209, 4'd5,  2'd3, 3'd6, 1'b1, 1'b0, 1'b1, 0},
        '{26'h000030e, 4'd6,  2'd1, 3'd2, 1'b1, 1'b0, 1'b1, 0},
        '{26'h0000413, 4'd7,  2'd2, 3'd4, 1'b0, 1'b1, 1'b0, 0},
        '{26'h0000510, 4'd8,  2'd0, 3'd7, 1'b1, 1'b0, 1'b1, 30},
        '{26'h0000617, 4'd9,  2'd3, 3'd3, 1'b1, 1'b0, 1'b1, 0},
        '{26'h000071a, 4'd10, 2'd1, 3'd1, 1'b1, 1'b0, 1'b1, 0},
        '{26'h0abcd5c, 4'd11, 2'd3, 3'd7, 1'b1, 1'b0, 1'b1, 0},
        '{26'h0abcd5c, 4'd12, 2'd2, 3'd0, 1'b1, 1'b0, 1'b1, 0},
        '{26'h3ffffff, 4'd13, 2'd0, 3'd5, 1'b0, 1'b1, 1'b0, 0},
        '{26'h1234567, 4'd14, 2'd1, 3'd2, 1'b1, 1'b0, 1'b1, 0}
    };

    logic      clk_i = 1'b0;
    logic      rst_ni;
    logic      miss_req_valid_i;
    miss_req_t miss_req_i;
    logic      miss_req_ready_o;
    logic      mem_req_valid_o;
    mem_req_t  mem_req_o;
    logic      mem_credit_i;
    logic      mem_rsp_valid_i;
    mem_rsp_t  mem_rsp_i;
    logic      core_rsp_valid_o;
    core_rsp_t core_rsp_o;
    logic      mshr_empty_o;
    logic      mshr_full_o;

    // Memory model and scoreboard state
    integer             seed;
    int                 cyc = 0;
    int                 cur_row = 0;
    int                 credits = REFILL_CREDITS;
    int                 owed = 0;
    int                 pause_left = 0;
    logic               ans_seen = 1'b0;
    int                 ans_row = 0;
    logic               pend_valid [NUM_SLOTS];
    int                 pend_due   [NUM_SLOTS];
    logic [NLINE_W-1:0] pend_nline [NUM_SLOTS];
    int                 pend_row   [NUM_SLOTS];
    int                 req_cnt    [NUM_ROWS];
    int                 rsp_cnt    [NUM_ROWS];

    miss_unit dut0 (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .miss_req_valid_i (miss_req_valid_i),
        .miss_req_i       (miss_req_i),
        .miss_req_ready_o (miss_req_ready_o),
        .mem_req_valid_o  (mem_req_valid_o),
        .mem_req_o        (mem_req_o),
        .mem_credit_i     (mem_credit_i),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_i        (mem_rsp_i),
        .core_rsp_valid_o (core_rsp_valid_o),
        .core_rsp_o       (core_rsp_o),
        .mshr_empty_o     (mshr_empty_o),
        .mshr_full_o      (mshr_full_o)
    );

    always #20 clk_i = ~clk_i;

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at time %0t: %s is %0b, expected %0b", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_mem_req(input mem_req_t got, input mem_req_t exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: mem_req %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    task automatic check_core_rsp(input core_rsp_t got, input core_rsp_t exp);
        if (got !== exp) begin
            $display("FAILED at time %0t: core_rsp %h, expected %h", $time, got, exp);
            abort_run();
        end
    endtask

    function automatic int pending_count();
        int n;
        n = 0;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            n += int'(pend_valid[s]);
        end
        return n;
    endfunction

    // Answers the lowest due slot and returns a credit with it
    always @(posedge clk_i) begin : memory_model
        int       pick;
        mem_rsp_t rsp;
        pick = -1;
        if (rst_ni) begin
            for (int s = NUM_SLOTS - 1; s >= 0; s--) begin
                if (pend_valid[s] && pend_due[s] <= cyc) begin
                    pick = s;
                end
            end
        end
        if (pick >= 0) begin
            rsp.id.slot     = ID_W'(pick);
            rsp.data        = DATA_W'(pend_nline[pick]) ^ 32'h5a5a0000;
            mem_rsp_valid_i <= 1'b1;
            mem_rsp_i       <= rsp;
            owed = owed + 1;
        end else begin
            mem_rsp_valid_i <= 1'b0;
        end
        if (pause_left > 0) begin
            pause_left = pause_left - 1;
            mem_credit_i <= 1'b0;
        end else if (owed > 0) begin
            owed = owed - 1;
            mem_credit_i <= 1'b1;
        end else begin
            mem_credit_i <= 1'b0;
        end
    end

    // Samples DUT outputs mid-cycle and keeps the scoreboard
    always @(negedge clk_i) begin : monitor
        core_rsp_t             want_rsp;
        mem_req_t              want_req;
        logic [MSHR_SET_W-1:0] mset;
        logic                  dup;
        int                    way;
        int                    slot;
        cyc = cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            abort_run();
        end
        if (rst_ni) begin
            // Status flags follow the refills still outstanding
            check_flag(mshr_empty_o, pending_count() == 0, "mshr_empty_o");
            check_flag(mshr_full_o, pending_count() == NUM_SLOTS, "mshr_full_o");
            // Core response due one cycle after an answer
            check_flag(core_rsp_valid_o, ans_seen && stim_table[ans_row].exp_rsp,
                       "core_rsp_valid_o");
            if (core_rsp_valid_o) begin
                want_rsp.tid  = stim_table[ans_row].tid;
                want_rsp.sid  = stim_table[ans_row].sid;
                want_rsp.word = stim_table[ans_row].word;
                want_rsp.data = DATA_W'(stim_table[ans_row].nline) ^ 32'h5a5a0000;
                check_core_rsp(core_rsp_o, want_rsp);
                rsp_cnt[ans_row]++;
            end
            ans_seen = mem_rsp_valid_i;
            if (mem_rsp_valid_i) begin
                ans_row = pend_row[mem_rsp_i.id.slot];
                pend_valid[mem_rsp_i.id.slot] = 1'b0;
            end
            check_flag(mem_req_valid_o, miss_req_ready_o, "mem_req_valid_o beside ready");
            if (mem_req_valid_o) begin
                mset = stim_table[cur_row].nline[MSHR_SET_W-1:0];
                check_flag(credits > 0, 1'b1, "credit available at refill request");
                // Lowest free way, and no refill already pending for this line
                way = -1;
                dup = 1'b0;
                for (int w = MSHR_WAYS - 1; w >= 0; w--) begin
                    if (!pend_valid[w * MSHR_SETS + int'(mset)]) begin
                        way = w;
                    end
                end
                for (int s = 0; s < NUM_SLOTS; s++) begin
                    if (pend_valid[s] && pend_nline[s] == stim_table[cur_row].nline) begin
                        dup = 1'b1;
                    end
                end
                check_flag(dup, 1'b0, "second refill for a pending line");
                check_flag(way >= 0, 1'b1, "free MSHR way at refill request");
                want_req.nline      = stim_table[cur_row].nline;
                want_req.id.loc.way = MSHR_WAY_W'(way);
                want_req.id.loc.set = mset;
                check_mem_req(mem_req_o, want_req);
                slot = int'(want_req.id.slot);
                pend_valid[slot] = 1'b1;
                pend_due[slot]   = cyc + 2 + int'($unsigned($random(seed)) % 5);
                pend_nline[slot] = stim_table[cur_row].nline;
                pend_row[slot]   = cur_row;
                credits = credits - 1;
                req_cnt[cur_row]++;
            end
            if (mem_credit_i) begin
                credits = credits + 1;
            end
        end
    end

    initial begin : stimulus
        miss_req_t req;
        seed = 32'he4688372;
        for (int s = 0; s < NUM_SLOTS; s++) begin
            pend_valid[s] = 1'b0;
            pend_due[s]   = 0;
            pend_nline[s] = '0;
            pend_row[s]   = 0;
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            req_cnt[r] = 0;
            rsp_cnt[r] = 0;
        end
        rst_ni           <= 1'b0;
        miss_req_valid_i <= 1'b0;
        miss_req_i       <= '0;
        mem_credit_i     <= 1'b0;
        mem_rsp_valid_i  <= 1'b0;
        mem_rsp_i        <= '0;
        repeat (10) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(negedge clk_i);
        check_flag(miss_req_ready_o, 1'b0, "miss_req_ready_o after reset");
        check_flag(mem_req_valid_o, 1'b0, "mem_req_valid_o after reset");
        check_flag(core_rsp_valid_o, 1'b0, "core_rsp_valid_o after reset");
        check_flag(mshr_empty_o, 1'b1, "mshr_empty_o after reset");

        // Present each row and hold it until accepted
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk_i);
            req.nline        = stim_table[r].nline;
            req.tid          = stim_table[r].tid;
            req.sid          = stim_table[r].sid;
            req.word         = stim_table[r].word;
            req.need_rsp     = stim_table[r].need_rsp;
            req.is_prefetch  = stim_table[r].is_prefetch;
            miss_req_valid_i <= 1'b1;
            miss_req_i       <= req;
            cur_row = r;
            @(negedge clk_i);
            if (stim_table[r].pause > 0) begin
                pause_left = stim_table[r].pause;
            end
            while (!miss_req_ready_o) begin
                @(negedge clk_i);
            end
        end
        @(posedge clk_i);
        miss_req_valid_i <= 1'b0;
        miss_req_i       <= '0;

        // Let every refill come back
        while (pending_count() != 0 || ans_seen) begin
            @(posedge clk_i);
        end
        @(negedge clk_i);
        check_flag(mshr_empty_o, 1'b1, "mshr_empty_o after all answers");
        for (int r = 0; r < NUM_ROWS; r++) begin
            check_flag(req_cnt[r] == 1, 1'b1, $sformatf("single refill for row %0d", r));
            check_flag(rsp_cnt[r] == int'(stim_table[r].exp_rsp), 1'b1,
                       $sformatf("core response count for row %0d", r));
        end
        $display("All tests passed");
        $finish;
    end

endmodule
